/* filelist.f */
design/pdpIsaPkg.sv
design/pdpCtrlPkg.sv
design/instDecoder.sv
design/memBusMaster.sv
design/accumulatorUnit.sv
design/cycleSequencer.sv
design/pdpCpu.sv
sim/pdpCpu_sva.sv
sim/pdpCpuTb.sv

/* sim/pdpCpuTb.sv */
// PDP-8 CPU testbench
`default_nettype none

module pdpCpuTb
  import pdpIsaPkg::*, pdpCtrlPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int numTests  = 6;
  localparam int haltLimit = 2000;

  logic   CLK;
  logic   rst       = 1'b1;
  logic   run       = 1'b0;
  logic   memAck    = 1'b0;
  wordT   memRdData = '0;
  logic   memReq;
  logic   memWe;
  addrT   memAddr;
  wordT   memWrData;
  logic   halted;
  addrT   pcOut;
  wordT   acOut;
  logic   linkOut;

  wordT       mem [0:4095];
  logic [1:0] ackWait;
  integer     seed       = 42253;
  int         checkCount = 0;
  int         errorCount = 0;

  pdpCpu dut0 (
    .CLK       (CLK),
    .rst       (rst),
    .run       (run),
    .memAck    (memAck),
    .memRdData (memRdData),
    .memReq    (memReq),
    .memWe     (memWe),
    .memAddr   (memAddr),
    .memWrData (memWrData),
    .halted    (halted),
    .pcOut     (pcOut),
    .acOut     (acOut),
    .linkOut   (linkOut)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Memory answers each request after 0 to 3 idle cycles
  always @(posedge CLK) begin
    if (rst) begin
      memAck  <= 1'b0;
      ackWait <= 2'($random(seed));
    end else if (memReq && !memAck) begin
      if (ackWait == 2'd0) begin
        memAck    <= 1'b1;
        memRdData <= mem[memAddr];
        if (memWe) begin
          mem[memAddr] <= memWrData;
        end
        // Delay for the next request
        ackWait <= 2'($random(seed));
      end else begin
        ackWait <= ackWait - 2'd1;
      end
    end else if (!memReq && memAck) begin
      // Phase 4 where ack follows req down
      memAck <= 1'b0;
    end
  end

  // Direct or indirect reference on the current page unless the target is in page zero
  function automatic wordT memRef(input opcodeT op, input logic ind, input addrT target);
    return {op, ind, |target[11:7], target[6:0]};
  endfunction

  // Link and AC as one 13-bit ring
  function automatic logic [12:0] rotl(input logic [12:0] v, input int n);
    return (v << n) | (v >> (13 - n));
  endfunction

  function automatic logic [12:0] rotr(input logic [12:0] v, input int n);
    return (v >> n) | (v << (13 - n));
  endfunction

  // SMA 0100, SZA 0040, SNL 0020, reverse 0010
  function automatic logic expectSkip(input wordT ac, input logic link, input wordT instr);
    logic cond;
    cond = (instr[6] && ac[11]) || (instr[5] && (ac == 12'o0000)) || (instr[4] && link);
    return instr[3] ? !cond : cond;
  endfunction

  // Every word differs so stale reads show up
  task automatic fillMemory();
    for (int i = 0; i < 4096; i++) begin
      mem[i] = wordT'(i) ^ 12'o3456;
    end
  endtask

  task automatic checkValue(input string name, input wordT expected, input wordT actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("** Error %s: expected %04o, actual %04o", name, expected, actual);
    end
  endtask

  // Reset, start at resetPc and wait for HLT
  task automatic runProgram(input string name);
    int cycles;
    cycles = 0;
    @(posedge CLK);
    rst <= 1'b1;
    repeat (3) @(posedge CLK);
    rst <= 1'b0;
    @(posedge CLK);
    run <= 1'b1;
    @(posedge CLK);
    run <= 1'b0;
    @(negedge CLK);
    while (!halted && cycles < haltLimit) begin
      @(negedge CLK);
      cycles++;
    end
    if (!halted) begin
      errorCount++;
      $display("%s: CPU still running after %0d cycles", name, haltLimit);
    end
  endtask

  // TAD, TAD, DCA with a carry out of bit 0
  task automatic runArithmeticTest();
    logic [12:0] sum;
    sum = {1'b0, 12'o7000} + {1'b0, 12'o1234};
    fillMemory();
    mem[resetPc]     = 12'o7300;
    mem[resetPc + 1] = memRef(opTad, 1'b0, 12'o0250);
    mem[resetPc + 2] = memRef(opTad, 1'b0, 12'o0251);
    mem[resetPc + 3] = memRef(opDca, 1'b0, 12'o0252);
    mem[resetPc + 4] = 12'o7402;
    mem[12'o0250]    = 12'o7000;
    mem[12'o0251]    = 12'o1234;
    runProgram("arithmetic");
    checkValue("arithmetic sum", sum[11:0], mem[12'o0252]);
    checkValue("arithmetic ac", 12'o0000, acOut);
    checkValue("arithmetic link", wordT'(sum[12]), wordT'(linkOut));
    checkValue("arithmetic pc", resetPc + 5, pcOut);
  endtask

  // AND through a page pointer, TAD through autoindex 0o10
  task automatic runIndirectTest();
    fillMemory();
    mem[resetPc]     = 12'o7300;
    mem[resetPc + 1] = memRef(opTad, 1'b0, 12'o0250);
    mem[resetPc + 2] = memRef(opAnd, 1'b1, 12'o0251);
    mem[resetPc + 3] = memRef(opDca, 1'b0, 12'o0252);
    mem[resetPc + 4] = memRef(opTad, 1'b1, 12'o0010);
    mem[resetPc + 5] = memRef(opDca, 1'b0, 12'o0253);
    mem[resetPc + 6] = 12'o7402;
    mem[12'o0250]    = 12'o7463;
    mem[12'o0251]    = 12'o0260;
    mem[12'o0260]    = 12'o3617;
    mem[12'o0010]    = 12'o0267;
    // Old pointer target that must not be used
    mem[12'o0267]    = 12'o0555;
    mem[12'o0270]    = 12'o0123;
    runProgram("indirect");
    checkValue("indirect and", 12'o7463 & 12'o3617, mem[12'o0252]);
    checkValue("autoindex pointer", 12'o0267 + 12'o0001, mem[12'o0010]);
    checkValue("autoindex operand", 12'o0123, mem[12'o0253]);
    checkValue("indirect pc", resetPc + 7, pcOut);
  endtask

  // Each DCA after an ISZ marks whether it ran
  task automatic runIszTest();
    fillMemory();
    mem[resetPc]     = memRef(opIsz, 1'b0, 12'o0250);
    mem[resetPc + 1] = memRef(opDca, 1'b0, 12'o0260);
    mem[resetPc + 2] = memRef(opIsz, 1'b0, 12'o0251);
    mem[resetPc + 3] = memRef(opDca, 1'b0, 12'o0261);
    mem[resetPc + 4] = 12'o7402;
    mem[12'o0250]    = 12'o7777;
    mem[12'o0251]    = 12'o0005;
    mem[12'o0260]    = 12'o1111;
    mem[12'o0261]    = 12'o2222;
    runProgram("isz");
    checkValue("isz wrap value", 12'o0000, mem[12'o0250]);
    checkValue("isz skipped marker", 12'o1111, mem[12'o0260]);
    checkValue("isz count value", 12'o0006, mem[12'o0251]);
    checkValue("isz executed marker", 12'o0000, mem[12'o0261]);
    checkValue("isz pc", resetPc + 5, pcOut);
  endtask

  // Subroutine at 0o300 returns by JMP I
  task automatic runSubroutineTest();
    fillMemory();
    mem[resetPc]     = 12'o7300;
    mem[resetPc + 1] = memRef(opJms, 1'b0, 12'o0300);
    mem[resetPc + 2] = memRef(opDca, 1'b0, 12'o0252);
    mem[resetPc + 3] = 12'o7402;
    mem[12'o0301]    = memRef(opTad, 1'b0, 12'o0251);
    mem[12'o0302]    = memRef(opJmp, 1'b1, 12'o0300);
    mem[12'o0251]    = 12'o0042;
    runProgram("subroutine");
    checkValue("jms return address", resetPc + 2, mem[12'o0300]);
    checkValue("subroutine result", 12'o0042, mem[12'o0252]);
    checkValue("subroutine pc", resetPc + 4, pcOut);
  endtask

  task automatic runGroup1Test();
    logic [12:0] afterRal;
    logic [12:0] afterRtr;
    wordT        swapped;
    // CLA CLL CMA IAC carries the increment into the link
    fillMemory();
    mem[resetPc]     = 12'o7341;
    mem[resetPc + 1] = 12'o7402;
    runProgram("group1 clear");
    checkValue("group1 clear ac", 12'o0000, acOut);
    checkValue("group1 clear link", 12'o0001, wordT'(linkOut));
    checkValue("group1 clear pc", resetPc + 2, pcOut);
    afterRal = rotl({1'b0, 12'o5432}, 1);
    afterRtr = rotr({afterRal[12], 12'o1234}, 2);
    swapped  = {6'(12'o6071), 6'(12'o6071 >> 6)};
    // RAL, RTR, then BSW with the link left alone
    fillMemory();
    mem[resetPc]     = 12'o7300;
    mem[resetPc + 1] = memRef(opTad, 1'b0, 12'o0250);
    mem[resetPc + 2] = 12'o7004;
    mem[resetPc + 3] = memRef(opDca, 1'b0, 12'o0260);
    mem[resetPc + 4] = memRef(opTad, 1'b0, 12'o0251);
    mem[resetPc + 5] = 12'o7012;
    mem[resetPc + 6] = memRef(opDca, 1'b0, 12'o0261);
    mem[resetPc + 7] = memRef(opTad, 1'b0, 12'o0252);
    mem[resetPc + 8] = 12'o7002;
    mem[resetPc + 9] = 12'o7402;
    mem[12'o0250]    = 12'o5432;
    mem[12'o0251]    = 12'o1234;
    mem[12'o0252]    = 12'o6071;
    runProgram("group1 rotate");
    checkValue("ral ac", afterRal[11:0], mem[12'o0260]);
    checkValue("rtr ac", afterRtr[11:0], mem[12'o0261]);
    checkValue("bsw ac", swapped, acOut);
    checkValue("bsw link", wordT'(afterRtr[12]), wordT'(linkOut));
    checkValue("group1 rotate pc", resetPc + 10, pcOut);
  endtask

  // Set AC and link, skip test, then a DCA onto the case marker
  task automatic runGroup2Test();
    wordT caseAc[8]   = '{12'o0000, 12'o0001, 12'o4000, 12'o0001,
                          12'o0000, 12'o0000, 12'o0002, 12'o0001};
    logic caseLink[8] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
    // SZA, SZA, SMA, SPA, SNL, SZL, SNA SZL, SMA SZA
    wordT caseSkip[8] = '{12'o7440, 12'o7440, 12'o7500, 12'o7510,
                          12'o7420, 12'o7430, 12'o7470, 12'o7540};
    addrT a;
    wordT expected;
    fillMemory();
    a = resetPc;
    for (int k = 0; k < 8; k++) begin
      mem[12'o0340 + k] = caseAc[k];
      mem[12'o0360 + k] = 12'o5555;
      // CLA CLL plus CML when the link must be set
      mem[a]     = caseLink[k] ? 12'o7320 : 12'o7300;
      mem[a + 1] = memRef(opTad, 1'b0, 12'o0340 + k);
      mem[a + 2] = caseSkip[k];
      mem[a + 3] = memRef(opDca, 1'b0, 12'o0360 + k);
      a = a + 12'd4;
    end
    mem[a] = 12'o7402;
    runProgram("group2");
    for (int k = 0; k < 8; k++) begin
      expected = expectSkip(caseAc[k], caseLink[k], caseSkip[k]) ? 12'o5555 : caseAc[k];
      checkValue($sformatf("group2 case %0d", k), expected, mem[12'o0360 + k]);
    end
    checkValue("group2 pc", a + 12'd1, pcOut);
  endtask

  initial begin
    runArithmeticTest();
    runIndirectTest();
    runIszTest();
    runSubroutineTest();
    runGroup1Test();
    runGroup2Test();
    $display("Checks: %0d, value errors: %0d, bus assertion failures: %0d",
             checkCount, errorCount, dut0.sva0.failCount);
    if (errorCount == 0 && dut0.sva0.failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Stops a hung run
  initial begin
    repeat (numTests * 2000) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, simulation stopped", numTests * 2000);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/pdpCpu_sva.sv */
// Memory bus and halt assertions
`default_nettype none

module pdpCpuSva
  import pdpIsaPkg::*;
(
  input  logic CLK,
  input  logic rst,
  input  logic memReq,
  input  logic memAck,
  input  logic memWe,
  input  addrT memAddr,
  input  wordT memWrData,
  input  logic halted
);

  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // Request fields hold until the memory answers
  property reqStable;
    @(posedge CLK) disable iff (rst)
      (memReq && !memAck) |=>
        (memReq && $stable(memWe) && $stable(memAddr) && $stable(memWrData));
  endproperty

  // Ack only answers a request
  property ackNeedsReq;
    @(posedge CLK) disable iff (rst)
      $rose(memAck) |-> $past(memReq);
  endproperty

  // Phase 4 must finish before the next request
  property reqAfterAckLow;
    @(posedge CLK) disable iff (rst)
      $rose(memReq) |-> !memAck;
  endproperty

  // Halted machine stays off the bus
  property quietWhenHalted;
    @(posedge CLK) disable iff (rst)
      halted |-> !memReq;
  endproperty

  aReqStable: assert property (reqStable) else begin
    failCount++;
    $error("memory request fields changed while waiting for ack");
  end

  aAckNeedsReq: assert property (ackNeedsReq) else begin
    failCount++;
    $error("memAck rose without a pending memReq");
  end

  aReqAfterAckLow: assert property (reqAfterAckLow) else begin
    failCount++;
    $error("memReq rose while memAck was still high");
  end

  aQuietWhenHalted: assert property (quietWhenHalted) else begin
    failCount++;
    $error("memReq high while the CPU is halted");
  end

endmodule

bind pdpCpu pdpCpuSva sva0 (
  .CLK       (CLK),
  .rst       (rst),
  .memReq    (memReq),
  .memAck    (memAck),
  .memWe     (memWe),
  .memAddr   (memAddr),
  .memWrData (memWrData),
  .halted    (halted)
);

`default_nettype wire

/* design/pdpCpu.sv */
// PDP-8 CPU top level
`default_nettype none

module pdpCpu
  import pdpIsaPkg::*;
(
  input  logic CLK,
  input  logic rst,
  input  logic run,
  input  logic memAck,
  input  wordT memRdData,
  output logic memReq,
  output logic memWe,
  output addrT memAddr,
  output wordT memWrData,
  output logic halted,
  output addrT pcOut,
  output wordT acOut,
  output logic linkOut
);

  // Decoder outputs
  opcodeT opcode;
  logic   indirect;
  logic   autoIndex;
  addrT   effAddr;
  wordT   oprBits;

  // Sequencer to bus master
  logic accessReq;
  logic accessWe;
  addrT accessAddr;
  wordT accessData;
  logic accessAck;
  wordT readData;

  // Sequencer to accumulator and back
  logic irLoad;
  logic acStrobe;
  wordT operand;
  logic skipTaken;
  wordT acValue;
  addrT pc;

  instDecoder uDecoder (
    .CLK       (CLK),
    .rst       (rst),
    .irLoad    (irLoad),
    .fetchWord (readData),
    .pc        (pc),
    .opcode    (opcode),
    .indirect  (indirect),
    .autoIndex (autoIndex),
    .effAddr   (effAddr),
    .oprBits   (oprBits)
  );

  cycleSequencer uSequencer (
    .CLK        (CLK),
    .rst        (rst),
    .run        (run),
    .opcode     (opcode),
    .indirect   (indirect),
    .autoIndex  (autoIndex),
    .effAddr    (effAddr),
    .oprBits    (oprBits),
    .accessAck  (accessAck),
    .readData   (readData),
    .skipTaken  (skipTaken),
    .acValue    (acValue),
    .accessReq  (accessReq),
    .accessWe   (accessWe),
    .accessAddr (accessAddr),
    .accessData (accessData),
    .irLoad     (irLoad),
    .acStrobe   (acStrobe),
    .operand    (operand),
    .halted     (halted),
    .pc         (pc)
  );

  memBusMaster uBusMaster (
    .CLK        (CLK),
    .rst        (rst),
    .accessReq  (accessReq),
    .accessWe   (accessWe),
    .accessAddr (accessAddr),
    .accessData (accessData),
    .memAck     (memAck),
    .memRdData  (memRdData),
    .accessAck  (accessAck),
    .readData   (readData),
    .memReq     (memReq),
    .memWe      (memWe),
    .memAddr    (memAddr),
    .memWrData  (memWrData)
  );

  accumulatorUnit uAccumulator (
    .CLK       (CLK),
    .rst       (rst),
    .acStrobe  (acStrobe),
    .opcode    (opcode),
    .oprBits   (oprBits),
    .operand   (operand),
    .acValue   (acValue),
    .linkValue (linkOut),
    .skipTaken (skipTaken)
  );

  assign pcOut = pc;
  assign acOut = acValue;

endmodule

`default_nettype wire

/* design/cycleSequencer.sv */
// Major-state cycle sequencer
`default_nettype none

module cycleSequencer
  import pdpIsaPkg::*, pdpCtrlPkg::*;
(
  input  logic   CLK,
  input  logic   rst,
  input  logic   run,
  input  opcodeT opcode,
  input  logic   indirect,
  input  logic   autoIndex,
  input  addrT   effAddr,
  input  wordT   oprBits,
  input  logic   accessAck,
  input  wordT   readData,
  input  logic   skipTaken,
  input  wordT   acValue,
  output logic   accessReq,
  output logic   accessWe,
  output addrT   accessAddr,
  output wordT   accessData,
  output logic   irLoad,
  output logic   acStrobe,
  output wordT   operand,
  output logic   halted,
  output addrT   pc
);

  majorStateT state;
  majorStateT opState;
  addrT       ptr;
  addrT       nextPtr;
  wordT       dataReg;
  logic       irValid;
  logic       memCycle;
  logic       group3;
  logic       hltOp;

  // Where a memory-reference instruction goes once its address is known
  function automatic majorStateT operandState(input opcodeT op);
    case (op)
      opDca:   return operandWrite;
      opJms:   return linkWrite;
      opJmp:   return fetch;
      default: return operandRead;
    endcase
  endfunction

  assign opState = operandState(opcode);
  assign group3  = oprBits[groupSelBit] && oprBits[g3MarkerBit];
  assign hltOp   = (opcode == opOpr) && oprBits[groupSelBit] && !group3 &&
                   oprBits[g2HltBit];

  // States that own a bus access, fetch only until the word is in
  assign memCycle = ((state == fetch) && !irValid) ||
                    (state inside {pointerRead, pointerWrite, operandRead,
                                   operandWrite, linkWrite});

  // Final operand address
  always_comb begin
    case (state)
      fetch:       nextPtr = effAddr;
      pointerRead: nextPtr = autoIndex ? readData + 12'd1 : readData;
      default:     nextPtr = ptr;
    endcase
  end

  // Bus request fields
  always_comb begin
    accessAddr = pc;
    accessWe   = 1'b0;
    accessData = dataReg;
    case (state)
      pointerRead: accessAddr = effAddr;
      pointerWrite: begin
        accessAddr = effAddr;
        accessWe   = 1'b1;
        accessData = ptr;
      end
      operandRead: accessAddr = ptr;
      operandWrite: begin
        accessAddr = ptr;
        accessWe   = 1'b1;
        accessData = (opcode == opDca) ? acValue : dataReg;
      end
      // JMS return address
      linkWrite: begin
        accessAddr = ptr;
        accessWe   = 1'b1;
        accessData = pc;
      end
      default: ;
    endcase
  end

  assign irLoad   = (state == fetch) && accessAck;
  assign acStrobe = (state == operate);
  assign operand  = dataReg;

  always_ff @(posedge CLK) begin
    if (rst) begin
      state     <= idle;
      pc        <= resetPc;
      ptr       <= '0;
      dataReg   <= '0;
      irValid   <= 1'b0;
      accessReq <= 1'b0;
      halted    <= 1'b1;
    end else begin
      // Request drops the cycle after each ack
      accessReq <= memCycle && !accessAck;
      case (state)
        idle: begin
          if (run) begin
            halted    <= 1'b0;
            accessReq <= 1'b1;
            state     <= fetch;
          end
        end
        fetch: begin
          if (irValid) begin
            // Dispatch on the freshly loaded IR
            irValid <= 1'b0;
            if (opcode == opOpr) begin
              if (!group3) state <= operate;
            end else if (opcode == opIot) begin
              state <= fetch;
            end else if (indirect) begin
              state <= pointerRead;
            end else begin
              ptr   <= nextPtr;
              state <= opState;
              if (opcode == opJmp) pc <= nextPtr;
            end
          end else if (accessAck) begin
            irValid <= 1'b1;
            pc      <= pc + 12'd1;
          end
        end
        pointerRead: begin
          if (accessAck) begin
            ptr <= nextPtr;
            if (autoIndex) begin
              state <= pointerWrite;
            end else begin
              state <= opState;
              if (opcode == opJmp) pc <= nextPtr;
            end
          end
        end
        // Write back the incremented pointer
        pointerWrite: begin
          if (accessAck) begin
            state <= opState;
            if (opcode == opJmp) pc <= nextPtr;
          end
        end
        operandRead: begin
          if (accessAck) begin
            dataReg <= (opcode == opIsz) ? readData + 12'd1 : readData;
            state   <= (opcode == opIsz) ? operandWrite : operate;
          end
        end
        operandWrite: begin
          if (accessAck) begin
            if (opcode == opDca) begin
              state <= operate;
            end else begin
              state <= (dataReg == '0) ? skip : fetch;
            end
          end
        end
        linkWrite: begin
          if (accessAck) begin
            pc    <= ptr + 12'd1;
            state <= fetch;
          end
        end
        operate: begin
          if (skipTaken) begin
            state <= skip;
          end else if (hltOp) begin
            halted <= 1'b1;
            state  <= idle;
          end else begin
            state <= fetch;
          end
        end
        skip: begin
          pc <= pc + 12'd1;
          if (hltOp) begin
            halted <= 1'b1;
            state  <= idle;
          end else begin
            state <= fetch;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/accumulatorUnit.sv */
// Accumulator, link and skip logic
`default_nettype none

module accumulatorUnit
  import pdpIsaPkg::*;
(
  input  logic   CLK,
  input  logic   rst,
  input  logic   acStrobe,
  input  opcodeT opcode,
  input  wordT   oprBits,
  input  wordT   operand,
  output wordT   acValue,
  output logic   linkValue,
  output logic   skipTaken
);

  wordT        ac;
  logic        link;
  logic        group1;
  logic        group2;
  logic [12:0] tadSum;
  wordT        claAc;
  wordT        cmaAc;
  wordT        iacAc;
  logic        cllLink;
  logic        cmlLink;
  logic        iacCarry;
  logic [12:0] rotIn;
  logic [12:0] rotOut;
  logic        anyCond;

  assign group1 = (opcode == opOpr) && !oprBits[groupSelBit];
  assign group2 = (opcode == opOpr) && oprBits[groupSelBit] && !oprBits[g3MarkerBit];

  // TAD carry out complements the link
  assign tadSum = {1'b0, ac} + {1'b0, operand};

  // Group 1 in sequence: clear, complement, increment, rotate
  always_comb begin
    claAc   = oprBits[g1ClaBit] ? '0 : ac;
    cllLink = oprBits[g1CllBit] ? 1'b0 : link;
    cmaAc   = oprBits[g1CmaBit] ? ~claAc : claAc;
    cmlLink = oprBits[g1CmlBit] ? ~cllLink : cllLink;
    {iacCarry, iacAc} = {1'b0, cmaAc} + 13'(oprBits[g1IacBit]);
    // Link and AC rotate as one 13-bit ring
    rotIn = {cmlLink ^ iacCarry, iacAc};
    if (oprBits[g1RarBit] && oprBits[g1TwoBit]) begin
      rotOut = {rotIn[1:0], rotIn[12:2]};
    end else if (oprBits[g1RarBit]) begin
      rotOut = {rotIn[0], rotIn[12:1]};
    end else if (oprBits[g1RalBit] && oprBits[g1TwoBit]) begin
      rotOut = {rotIn[10:0], rotIn[12:11]};
    end else if (oprBits[g1RalBit]) begin
      rotOut = {rotIn[11:0], rotIn[12]};
    end else if (oprBits[g1BswBit]) begin
      // Swap 6-bit halves, link untouched
      rotOut = {rotIn[12], rotIn[5:0], rotIn[11:6]};
    end else begin
      rotOut = rotIn;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      ac   <= '0;
      link <= 1'b0;
    end else if (acStrobe) begin
      case (opcode)
        opAnd: ac <= ac & operand;
        opTad: begin
          ac   <= tadSum[11:0];
          link <= link ^ tadSum[12];
        end
        // DCA clears after the store
        opDca: ac <= '0;
        opOpr: begin
          if (group1) begin
            {link, ac} <= rotOut;
          end else if (group2 && oprBits[g2ClaBit]) begin
            ac <= '0;
          end
        end
        default: ;
      endcase
    end
  end

  // Skip test sees AC before any group 2 clear
  assign anyCond = (oprBits[g2SmaBit] && ac[11]) ||
                   (oprBits[g2SzaBit] && (ac == '0)) ||
                   (oprBits[g2SnlBit] && link);

  // Reverse sense skips only when every selected condition fails
  assign skipTaken = group2 && (oprBits[g2RevBit] ? !anyCond : anyCond);

  assign acValue   = ac;
  assign linkValue = link;

endmodule

`default_nettype wire

/* design/memBusMaster.sv */
// Four-phase memory bus master
`default_nettype none

module memBusMaster
  import pdpIsaPkg::*, pdpCtrlPkg::*;
(
  input  logic CLK,
  input  logic rst,
  input  logic accessReq,
  input  logic accessWe,
  input  addrT accessAddr,
  input  wordT accessData,
  input  logic memAck,
  input  wordT memRdData,
  output logic accessAck,
  output wordT readData,
  output logic memReq,
  output logic memWe,
  output addrT memAddr,
  output wordT memWrData
);

  busStateT busState;
  logic     startReq;
  logic     captureRd;

  // The request is still up on the cycle of our own ack, so skip it
  assign startReq  = (busState == busIdle) && accessReq && !accessAck && !memAck;
  assign captureRd = (busState == busReq) && memAck;

  always_ff @(posedge CLK) begin
    if (rst) begin
      busState  <= busIdle;
      memReq    <= 1'b0;
      memWe     <= 1'b0;
      accessAck <= 1'b0;
    end else begin
      accessAck <= 1'b0;
      case (busState)
        busIdle: begin
          if (startReq) begin
            memReq   <= 1'b1;
            memWe    <= accessWe;
            busState <= busReq;
          end
        end
        busReq: begin
          // Phase 2, memory has answered
          if (memAck) begin
            memReq   <= 1'b0;
            memWe    <= 1'b0;
            busState <= busRelease;
          end
        end
        busRelease: begin
          // Complete only once the ack is back down
          if (!memAck) begin
            accessAck <= 1'b1;
            busState  <= busIdle;
          end
        end
        default: busState <= busIdle;
      endcase
    end
  end

  // Address, write data and read word
  always_ff @(posedge CLK) begin
    if (startReq) begin
      memAddr   <= accessAddr;
      memWrData <= accessData;
    end
    if (captureRd) begin
      readData <= memRdData;
    end
  end

endmodule

`default_nettype wire

/* design/instDecoder.sv */
// Instruction decoder
`default_nettype none

module instDecoder
  import pdpIsaPkg::*;
(
  input  logic   CLK,
  input  logic   rst,
  input  logic   irLoad,
  input  wordT   fetchWord,
  input  addrT   pc,
  output opcodeT opcode,
  output logic   indirect,
  output logic   autoIndex,
  output addrT   effAddr,
  output wordT   oprBits
);

  wordT ir;
  logic memRef;
  logic currentPage;
  addrT pageBase;

  // Instruction register
  always_ff @(posedge CLK) begin
    if (rst) begin
      ir <= '0;
    end else if (irLoad) begin
      ir <= fetchWord;
    end
  end

  assign opcode = opcodeT'(ir[11:9]);

  // IOT and OPR carry no address field
  assign memRef      = (opcode != opIot) && (opcode != opOpr);
  assign indirect    = memRef && ir[indirectBit];
  assign currentPage = ir[currentPageBit];

  // Page bits of the PC, which already points past this instruction
  assign pageBase = currentPage ? {pc[$bits(addrT)-1:pageOffsetW], {pageOffsetW{1'b0}}}
                                : '0;
  assign effAddr  = pageBase | addrT'(ir[pageOffsetW-1:0]);

  // Indirect through 0o10..0o17 of page zero
  assign autoIndex = indirect && !currentPage &&
                     (effAddr >= autoIndexLo) && (effAddr <= autoIndexHi);

  // Micro-op bits go out whole
  assign oprBits = ir;

endmodule

`default_nettype wire

/* design/pdpCtrlPkg.sv */
// PDP-8 machine control
`default_nettype none

package pdpCtrlPkg;

  import pdpIsaPkg::*;

  // Major states of the instruction cycle
  typedef enum logic [3:0] {
    idle,
    fetch,
    pointerRead,
    pointerWrite,
    operandRead,
    operandWrite,
    linkWrite,
    operate,
    skip
  } majorStateT;

  // Four-phase bus master states
  typedef enum logic [1:0] {
    busIdle,
    busReq,
    busRelease
  } busStateT;

  // Start address after reset
  localparam addrT resetPc = 12'o0200;

endpackage

`default_nettype wire

/* design/pdpIsaPkg.sv */
// PDP-8 instruction set
`default_nettype none

package pdpIsaPkg;

  // Data word and memory address, both 12 bits
  typedef logic [11:0] wordT;
  typedef logic [11:0] addrT;

  // Major opcode in instruction bits 11:9
  typedef enum logic [2:0] {
    opAnd = 3'o0,
    opTad = 3'o1,
    opIsz = 3'o2,
    opDca = 3'o3,
    opJms = 3'o4,
    opJmp = 3'o5,
    opIot = 3'o6,
    opOpr = 3'o7
  } opcodeT;

  // Memory-reference fields
  localparam int pageOffsetW    = 7;
  localparam int currentPageBit = 7;
  localparam int indirectBit    = 8;

  // Page-zero pointers that increment before use
  localparam addrT autoIndexLo = 12'o0010;
  localparam addrT autoIndexHi = 12'o0017;

  // Operate word, clear for group 1
  localparam int groupSelBit = 8;

  // Group 1 micro-ops
  localparam int g1ClaBit = 7;
  localparam int g1CllBit = 6;
  localparam int g1CmaBit = 5;
  localparam int g1CmlBit = 4;
  localparam int g1RarBit = 3;
  localparam int g1RalBit = 2;
  // Rotate twice with RAR or RAL, byte swap on its own
  localparam int g1TwoBit = 1;
  localparam int g1BswBit = 1;
  localparam int g1IacBit = 0;

  // Group 2 micro-ops
  localparam int g2ClaBit = 7;
  localparam int g2SmaBit = 6;
  localparam int g2SzaBit = 5;
  localparam int g2SnlBit = 4;
  localparam int g2RevBit = 3;
  localparam int g2HltBit = 1;
  // Set together with groupSelBit for group 3
  localparam int g3MarkerBit = 0;

endpackage

`default_nettype wire
